// ==== Bender.yml ====
package:
  name: pcie_rx_dma_app

sources:
  - files:
      - pcie_app_pkg.sv
      - bar_write_decoder.sv
      - huge_page_regs.sv
      - rx_dma_ctrl.sv
      - tlp_tx_builder.sv
      - pcie_rx_dma_app.sv
  - target: test
    files:
      - tb_pcie_rx_dma_app.sv

// ==== bar_write_decoder.sv ====
`timescale 1ns/100ps
// Snoops the RX local-link for single-dword memory writes that hit BAR0
// Emits one register-write strobe per matching TLP, one cycle after its eof
module bar_write_decoder (
    input  logic                   trn_clk,
    input  logic                   rst_n,
    input  pcie_app_pkg::ll_beat_t rx_beat,
    input  logic [6:0]             bar_hit_n,
    output pcie_app_pkg::reg_wr_t  reg_wr
);
    import pcie_app_pkg::*;

    logic     in_tlp;                           // Between sof and eof
    logic     second_beat;                      // Current beat directly follows sof
    logic     hdr_match;                        // Latched header check of open TLP
    logic     hdr_ok;
    logic     data_hit;
    logic     wr_valid;
    reg_off_t wr_off;
    dword_t   wr_data;

    // Header dword 0 sits in the upper half of the sof beat
    assign hdr_ok = (rx_beat.data[63:56] == BAR_MWR32) &&
                    (rx_beat.data[41:32] == 10'd1) &&
                    !bar_hit_n[0];

    // Second beat carries address in upper dword and data in lower dword
    assign data_hit = rx_beat.src_rdy && second_beat && hdr_match &&
                      rx_beat.eof && (rx_beat.rem_n == 8'h00);

    always_ff @(posedge trn_clk) begin
        if (!rst_n) begin
            in_tlp      <= 1'b0;
            second_beat <= 1'b0;
            hdr_match   <= 1'b0;
        end else if (rx_beat.src_rdy) begin
            in_tlp      <= !rx_beat.eof;
            second_beat <= rx_beat.sof && !rx_beat.eof;
            if (rx_beat.sof) begin
                hdr_match <= hdr_ok;
            end
        end
    end

    always_ff @(posedge trn_clk) begin
        if (!rst_n) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= data_hit;               // Pulse one cycle after eof
        end
    end

    always_ff @(posedge trn_clk) begin
        if (data_hit) begin
            wr_off  <= rx_beat.data[36:32];     // Low address bits
            wr_data <= rx_beat.data[31:0];
        end
    end

    assign reg_wr = '{valid: wr_valid, offset: wr_off, data: wr_data};

    // A new TLP may only start once the previous one has seen its eof
    a_sof_closed: assert property (@(posedge trn_clk) disable iff (!rst_n)
        rx_beat.src_rdy && rx_beat.sof |-> !in_tlp);

endmodule

// ==== huge_page_regs.sv ====
`timescale 1ns/100ps
// Host-visible huge-page descriptors and interrupt enable behind BAR0
// Written by the BAR decoder strobes, pages released by the DMA controller
module huge_page_regs (
    input  logic                  trn_clk,
    input  logic                  rst_n,
    input  pcie_app_pkg::reg_wr_t reg_wr,
    input  logic                  free_1,
    input  logic                  free_2,
    output pcie_app_pkg::page_t   page_1,
    output pcie_app_pkg::page_t   page_2,
    output logic                  int_en
);
    import pcie_app_pkg::*;

    localparam reg_off_t LO_OFF [2] = '{REG_PAGE1_LO, REG_PAGE2_LO};
    localparam reg_off_t HI_OFF [2] = '{REG_PAGE1_HI, REG_PAGE2_HI};

    host_addr_t addr_q [2];
    logic [1:0] ready_q;
    logic [1:0] free;

    assign free = {free_2, free_1};

    for (genvar i = 0; i < 2; i++) begin : g_page
        logic lo_wr;
        logic hi_wr;

        assign lo_wr = reg_wr.valid && (reg_wr.offset == LO_OFF[i]);
        assign hi_wr = reg_wr.valid && (reg_wr.offset == HI_OFF[i]);

        always_ff @(posedge trn_clk) begin
            if (!rst_n) begin
                ready_q[i] <= 1'b0;
            end else if (hi_wr) begin
                ready_q[i] <= 1'b1;             // HI write completes registration
            end else if (free[i]) begin
                ready_q[i] <= 1'b0;
            end
        end

        always_ff @(posedge trn_clk) begin
            if (lo_wr) begin
                addr_q[i][31:0] <= reg_wr.data;
            end
            if (hi_wr) begin
                addr_q[i][63:32] <= reg_wr.data;
            end
        end

        // Controller only releases a page it has been writing into
        a_free_ready: assert property (@(posedge trn_clk) disable iff (!rst_n)
            free[i] |-> ready_q[i]);
    end

    // --------------------
    // Interrupt enable
    // --------------------
    always_ff @(posedge trn_clk) begin
        if (!rst_n) begin
            int_en <= 1'b0;
        end else if (reg_wr.valid && (reg_wr.offset == REG_INT_EN)) begin
            int_en <= reg_wr.data[0];
        end
    end

    assign page_1 = '{addr: addr_q[0], ready: ready_q[0]};
    assign page_2 = '{addr: addr_q[1], ready: ready_q[1]};

endmodule

// ==== pcie_app_pkg.sv ====
// Widths, TLP codes, BAR0 register map and shared types of the RX DMA endpoint app
// Every RTL module of the receive path imports what it needs from here
package pcie_app_pkg;

    // --------------------
    // Sizes and codes
    // --------------------
    localparam int BUF_AW     = 10;             // RX buffer RAM address bits
    localparam int MAX_QWORDS = 16;             // Largest payload of one TLP

    localparam logic [7:0] BAR_MWR32 = 8'h40;   // 3DW memory write with data
    localparam logic [7:0] TLP_MWR64 = 8'h60;   // 4DW memory write with data
    localparam logic [7:0] FULL_BE   = 8'hFF;   // Last BE and first BE all set

    typedef logic [63:0]       qword_t;         // One TRN data beat
    typedef logic [31:0]       dword_t;
    typedef logic [63:0]       host_addr_t;     // Host physical address
    typedef logic [BUF_AW-1:0] buf_addr_t;      // RX buffer RAM word address
    typedef logic [4:0]        qword_cnt_t;     // Qwords per TLP
    typedef logic [4:0]        reg_off_t;       // Byte offset inside BAR0
    typedef logic [15:0]       completer_id_t;  // Bus, device, function

    // --------------------
    // BAR0 register map
    // --------------------
    localparam reg_off_t REG_PAGE1_LO = 5'h00;
    localparam reg_off_t REG_PAGE1_HI = 5'h04;
    localparam reg_off_t REG_PAGE2_LO = 5'h08;
    localparam reg_off_t REG_PAGE2_HI = 5'h0C;
    localparam reg_off_t REG_INT_EN   = 5'h10;  // Bit 0 enables the legacy interrupt

    // One RX local-link beat, strobes active high
    typedef struct packed {
        qword_t     data;
        logic [7:0] rem_n;
        logic       sof;
        logic       eof;
        logic       src_rdy;
    } ll_beat_t;

    typedef struct packed {
        logic       valid;                      // Single-cycle strobe
        reg_off_t   offset;
        dword_t     data;
    } reg_wr_t;

    typedef struct packed {
        host_addr_t addr;
        logic       ready;                      // Registered by host and not yet freed
    } page_t;

    typedef struct packed {
        host_addr_t addr;                       // Host address of the first payload byte
        qword_cnt_t qwords;
        buf_addr_t  buf_start;                  // First RAM word of the payload
    } tlp_req_t;

    typedef enum logic [2:0] {
        IDLE,
        SEND,
        WAIT_TLP,
        IRQ,
        IRQ_WAIT
    } ctrl_state_e;

endpackage

// ==== pcie_rx_dma_app.sv ====
`timescale 1ns/100ps
// Receive-side PCIe endpoint application on the 64-bit TRN local-link
// Connects BAR0 decode, page registers, DMA control and TLP builder
module pcie_rx_dma_app (
    input  logic                     trn_clk,
    input  logic                     rst_n,
    // RX local-link
    input  pcie_app_pkg::qword_t     trn_rd,
    input  logic [7:0]               trn_rrem,
    input  logic                     trn_rsof_n,
    input  logic                     trn_reof_n,
    input  logic                     trn_rsrc_rdy_n,
    input  logic [6:0]               trn_rbar_hit_n,
    output logic                     trn_rdst_rdy_n,
    // TX local-link
    output pcie_app_pkg::qword_t     trn_td,
    output logic [7:0]               trn_trem_n,
    output logic                     trn_tsof_n,
    output logic                     trn_teof_n,
    output logic                     trn_tsrc_rdy_n,
    output logic                     trn_tsrc_dsc_n,
    input  logic                     trn_tdst_rdy_n,
    input  logic [3:0]               trn_tbuf_av,
    // Configuration space
    input  logic [15:0]              cfg_command,
    input  logic [7:0]               cfg_bus_number,
    input  logic [4:0]               cfg_device_number,
    input  logic [2:0]               cfg_function_number,
    output logic                     cfg_interrupt_n,
    input  logic                     cfg_interrupt_rdy_n,
    // MAC side
    input  logic                     rx_trigger_tlp,
    output logic                     rx_trigger_tlp_ack,
    input  pcie_app_pkg::qword_cnt_t rx_qwords_to_send,
    input  logic                     rx_change_huge_page,
    output logic                     rx_change_huge_page_ack,
    output logic                     rx_huge_page_status_1,
    output logic                     rx_huge_page_status_2,
    output pcie_app_pkg::buf_addr_t  rx_commited_rd_address,
    // RX buffer RAM
    output pcie_app_pkg::buf_addr_t  rx_rd_addr,
    input  pcie_app_pkg::qword_t     rx_rd_data
);
    import pcie_app_pkg::*;

    ll_beat_t      rx_beat;
    reg_wr_t       reg_wr;
    page_t         page_1;
    page_t         page_2;
    logic          int_en;
    logic          free_1;
    logic          free_2;
    tlp_req_t      tlp_req;
    logic          tlp_start;
    logic          tlp_done;
    completer_id_t completer_id;
    logic          bus_mstr_en;

    // --------------------
    // Glue and tie-offs
    // --------------------
    assign rx_beat = '{data: trn_rd, rem_n: trn_rrem, sof: !trn_rsof_n,
                       eof: !trn_reof_n, src_rdy: !trn_rsrc_rdy_n};
    assign completer_id   = {cfg_bus_number, cfg_device_number, cfg_function_number};
    assign bus_mstr_en    = cfg_command[2];     // Bus master enable bit
    assign trn_rdst_rdy_n = 1'b0;               // Always accept RX beats
    assign trn_tsrc_dsc_n = 1'b1;               // Never discontinue
    assign trn_trem_n     = 8'h00;              // Every beat is a full qword

    assign rx_huge_page_status_1 = page_1.ready;
    assign rx_huge_page_status_2 = page_2.ready;

    bar_write_decoder bar_write_decoder_mod (
        .trn_clk(trn_clk), .rst_n(rst_n), .rx_beat(rx_beat),
        .bar_hit_n(trn_rbar_hit_n), .reg_wr(reg_wr)
    );

    huge_page_regs huge_page_regs_mod (
        .trn_clk(trn_clk), .rst_n(rst_n), .reg_wr(reg_wr),
        .free_1(free_1), .free_2(free_2),
        .page_1(page_1), .page_2(page_2), .int_en(int_en)
    );

    rx_dma_ctrl rx_dma_ctrl_mod (
        .trn_clk(trn_clk), .rst_n(rst_n),
        .page_1(page_1), .page_2(page_2), .int_en(int_en),
        .bus_mstr_en(bus_mstr_en), .tbuf_av(trn_tbuf_av),
        .trigger_tlp(rx_trigger_tlp), .qwords_to_send(rx_qwords_to_send),
        .change_huge_page(rx_change_huge_page), .tlp_done(tlp_done),
        .cfg_interrupt_rdy_n(cfg_interrupt_rdy_n),
        .free_1(free_1), .free_2(free_2),
        .trigger_tlp_ack(rx_trigger_tlp_ack),
        .change_huge_page_ack(rx_change_huge_page_ack),
        .tlp_req(tlp_req), .tlp_start(tlp_start),
        .commited_rd_address(rx_commited_rd_address),
        .cfg_interrupt_n(cfg_interrupt_n)
    );

    tlp_tx_builder tlp_tx_builder_mod (
        .trn_clk(trn_clk), .rst_n(rst_n),
        .tlp_req(tlp_req), .tlp_start(tlp_start), .completer_id(completer_id),
        .rd_data(rx_rd_data), .trn_tdst_rdy_n(trn_tdst_rdy_n),
        .rd_addr(rx_rd_addr), .trn_td(trn_td),
        .trn_tsof_n(trn_tsof_n), .trn_teof_n(trn_teof_n),
        .trn_tsrc_rdy_n(trn_tsrc_rdy_n), .tlp_done(tlp_done)
    );

endmodule

// ==== project.f ====
pcie_app_pkg.sv
bar_write_decoder.sv
huge_page_regs.sv
rx_dma_ctrl.sv
tlp_tx_builder.sv
pcie_rx_dma_app.sv
tb_pcie_rx_dma_app.sv

// ==== rx_dma_ctrl.sv ====
`timescale 1ns/100ps
// Serves MAC-side trigger and page-change requests for the RX DMA path
// Hands one TLP at a time to the builder and raises the page-close interrupt
module rx_dma_ctrl (
    input  logic                     trn_clk,
    input  logic                     rst_n,
    input  pcie_app_pkg::page_t      page_1,
    input  pcie_app_pkg::page_t      page_2,
    input  logic                     int_en,
    input  logic                     bus_mstr_en,
    input  logic [3:0]               tbuf_av,
    input  logic                     trigger_tlp,
    input  pcie_app_pkg::qword_cnt_t qwords_to_send,
    input  logic                     change_huge_page,
    input  logic                     tlp_done,
    input  logic                     cfg_interrupt_rdy_n,
    output logic                     free_1,
    output logic                     free_2,
    output logic                     trigger_tlp_ack,
    output logic                     change_huge_page_ack,
    output pcie_app_pkg::tlp_req_t   tlp_req,
    output logic                     tlp_start,
    output pcie_app_pkg::buf_addr_t  commited_rd_address,
    output logic                     cfg_interrupt_n
);
    import pcie_app_pkg::*;

    ctrl_state_e state;
    logic        cur_sel;                       // 0 selects page 1
    page_t       cur_page;
    host_addr_t  page_off;                      // Byte offset inside current page
    logic        take_trig;

    assign cur_page  = cur_sel ? page_2 : page_1;
    assign take_trig = (state == IDLE) && !change_huge_page && trigger_tlp &&
                       cur_page.ready && bus_mstr_en && (tbuf_av != 4'd0);

    assign tlp_start            = (state == SEND);
    assign trigger_tlp_ack      = (state == WAIT_TLP) && tlp_done;  // Same cycle as last beat
    assign change_huge_page_ack = (state == IRQ_WAIT);

    // --------------------
    // Control FSM
    // --------------------
    always_ff @(posedge trn_clk) begin
        if (!rst_n) begin
            state               <= IDLE;
            cur_sel             <= 1'b0;
            page_off            <= '0;
            commited_rd_address <= '0;
            free_1              <= 1'b0;
            free_2              <= 1'b0;
            cfg_interrupt_n     <= 1'b1;
        end else begin
            free_1 <= 1'b0;
            free_2 <= 1'b0;
            case (state)
                IDLE: begin
                    if (change_huge_page) begin
                        free_1   <= !cur_sel;   // Release the page being closed
                        free_2   <= cur_sel;
                        cur_sel  <= !cur_sel;
                        page_off <= '0;
                        if (int_en) begin
                            cfg_interrupt_n <= 1'b0;
                            state           <= IRQ;
                        end else begin
                            state <= IRQ_WAIT;
                        end
                    end else if (take_trig) begin
                        state <= SEND;
                    end
                end
                SEND: state <= WAIT_TLP;        // Builder latches request here
                WAIT_TLP: begin
                    if (tlp_done) begin
                        commited_rd_address <= commited_rd_address +
                                               buf_addr_t'(tlp_req.qwords);
                        page_off <= page_off + host_addr_t'({tlp_req.qwords, 3'b000});
                        state    <= IDLE;
                    end
                end
                IRQ: begin
                    if (!cfg_interrupt_rdy_n) begin
                        cfg_interrupt_n <= 1'b1;    // Core took the interrupt
                        state           <= IRQ_WAIT;
                    end
                end
                IRQ_WAIT: state <= IDLE;        // Ack cycle of the page change
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge trn_clk) begin
        if (take_trig) begin
            tlp_req <= '{addr:      cur_page.addr + page_off,
                         qwords:    qwords_to_send,
                         buf_start: commited_rd_address};
        end
    end

    // MAC side must hold a legal size for the whole request
    a_qwords_range: assert property (@(posedge trn_clk) disable iff (!rst_n)
        trigger_tlp |-> (qwords_to_send >= 1) && (qwords_to_send <= MAX_QWORDS));

endmodule

// ==== tb_pcie_rx_dma_app.sv ====
`timescale 1ns/100ps
// Directed testbench for the RX DMA endpoint app with buffer RAM and interrupt models
// Collects TX beats per TLP and checks header, address, payload and handshakes
module tb_pcie_rx_dma_app;
    import pcie_app_pkg::*;

    localparam int WAIT_LIMIT = 200;            // Longest single handshake
    localparam int RUN_LIMIT  = 4000;           // Five tests of well under 800 cycles each

    localparam host_addr_t PAGE1 = 64'h0000_0012_3440_0000;
    localparam host_addr_t PAGE2 = 64'h0000_0056_7880_0000;
    localparam host_addr_t PAGE3 = 64'h0000_009A_BC00_0000;   // Page 1 re-registered

    logic          trn_clk;
    logic          rst_n;
    qword_t        trn_rd;
    logic [7:0]    trn_rrem;
    logic          trn_rsof_n;
    logic          trn_reof_n;
    logic          trn_rsrc_rdy_n;
    logic [6:0]    trn_rbar_hit_n;
    logic          trn_rdst_rdy_n;
    qword_t        trn_td;
    logic [7:0]    trn_trem_n;
    logic          trn_tsof_n;
    logic          trn_teof_n;
    logic          trn_tsrc_rdy_n;
    logic          trn_tsrc_dsc_n;
    logic          trn_tdst_rdy_n;
    logic [3:0]    trn_tbuf_av;
    logic [15:0]   cfg_command;
    logic [7:0]    cfg_bus_number;
    logic [4:0]    cfg_device_number;
    logic [2:0]    cfg_function_number;
    logic          cfg_interrupt_n;
    logic          cfg_interrupt_rdy_n;
    logic          rx_trigger_tlp;
    logic          rx_trigger_tlp_ack;
    qword_cnt_t    rx_qwords_to_send;
    logic          rx_change_huge_page;
    logic          rx_change_huge_page_ack;
    logic          rx_huge_page_status_1;
    logic          rx_huge_page_status_2;
    buf_addr_t     rx_commited_rd_address;
    buf_addr_t     rx_rd_addr;
    qword_t        rx_rd_data;

    int            value_errs;
    int            other_errs;
    int            cycle;
    integer        seed;
    logic          bp_en;                       // Random TX back-pressure on
    qword_t        beat_q [$];                  // Accepted TX beats of current TLP
    int            mon_pos;
    int            ack_cnt;
    int            irq_cnt;
    int            irq_low;                     // Cycles cfg_interrupt_n seen low
    logic          irq_seen;
    logic          rdy_given;
    buf_addr_t     ram_addr;
    buf_addr_t     exp_ptr;                     // Expected committed pointer
    host_addr_t    exp_off;                     // Expected offset in current page

    pcie_rx_dma_app i_dut (.*);

    initial begin
        trn_clk = 1'b0;
        forever #2 trn_clk = ~trn_clk;
    end

    // Every RAM address bit shows up twice in the pattern
    function automatic qword_t ram_word(buf_addr_t a);
        return {16'hFEED, 6'd0, a, 16'h5A5A, ~{6'd0, a}};
    endfunction

    // --------------------
    // Models and monitor
    // --------------------
    always @(posedge trn_clk) begin
        ram_addr = rx_rd_addr;
        #1 rx_rd_data = ram_word(ram_addr);     // Sync RAM with one cycle latency
    end

    always @(posedge trn_clk) begin
        if (!trn_tsrc_rdy_n && !trn_tdst_rdy_n) begin
            beat_q.push_back(trn_td);
            if ((!trn_tsof_n) != (mon_pos == 0)) begin
                other_errs++;
                $display("TX start of frame missing or misplaced at beat %0d", mon_pos);
            end
            check_bit("tx beat tsrc_dsc_n", 1'b1, trn_tsrc_dsc_n);
            check_bit("tx beat trem_n any bit set", 1'b0, |trn_trem_n);
            mon_pos = trn_teof_n ? mon_pos + 1 : 0;
        end
        if (rx_trigger_tlp_ack) begin
            ack_cnt++;
        end
        #1 trn_tdst_rdy_n = bp_en ? (($random(seed) & 3) == 0) : 1'b0;
    end

    // Core grants the interrupt on the third low cycle
    always @(posedge trn_clk) begin
        irq_seen = !cfg_interrupt_n;
        #1;
        if (!irq_seen || !rst_n) begin
            irq_low = 0;
        end else begin
            irq_low++;
        end
        if (irq_low == 1) begin
            irq_cnt++;
        end
        if (irq_low == 3) begin
            rdy_given = 1'b1;
        end
        cfg_interrupt_rdy_n = (irq_low != 3);
    end

    // --------------------
    // Check tasks
    // --------------------
    task automatic check_qword(string name, qword_t exp, qword_t act);
        if (exp !== act) begin
            value_errs++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(string name, buf_addr_t exp, buf_addr_t act);
        if (exp !== act) begin
            value_errs++;
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            value_errs++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // --------------------
    // Drivers
    // --------------------
    task automatic tick();
        @(posedge trn_clk);
        #1;
    endtask

    task automatic bar_write(reg_off_t off, dword_t data, logic hit);
        tick();
        trn_rsrc_rdy_n = 1'b0;
        trn_rsof_n     = 1'b0;
        trn_rbar_hit_n = {6'h3F, !hit};
        trn_rd         = {8'h40, 14'd0, 10'd1, 16'h0100, 8'h00, 8'h0F};
        check_bit("rx rdst_rdy_n", 1'b0, trn_rdst_rdy_n);
        tick();
        trn_rsof_n = 1'b1;
        trn_reof_n = 1'b0;
        trn_rd     = {27'h780_0000, off, data};  // Address dword, then data dword
        tick();
        trn_rsrc_rdy_n = 1'b1;
        trn_reof_n     = 1'b1;
        trn_rbar_hit_n = 7'h7F;
        repeat (3) tick();                      // Status follows two cycles after eof
    endtask

    task automatic start_trigger(qword_cnt_t n);
        tick();
        beat_q.delete();
        rx_qwords_to_send = n;
        rx_trigger_tlp    = 1'b1;
    endtask

    task automatic await_tlp(string name, qword_cnt_t n, host_addr_t base);
        int waited;
        int acks;
        waited = 0;
        acks   = ack_cnt;
        do begin
            @(negedge trn_clk);
            waited++;
        end while (!rx_trigger_tlp_ack && waited < WAIT_LIMIT);
        tick();
        rx_trigger_tlp = 1'b0;
        if (waited >= WAIT_LIMIT) begin
            other_errs++;
            $display("%s: trigger was not acknowledged within %0d cycles", name, WAIT_LIMIT);
            return;
        end
        check_bit({name, " beat count"}, 1'b1, beat_q.size() == n + 2);
        if (beat_q.size() == n + 2) begin
            check_qword({name, " header"}, {8'h60, 14'd0, 10'(2 * n),
                        cfg_bus_number, cfg_device_number, cfg_function_number,
                        8'h00, 8'hFF}, beat_q[0]);
            check_qword({name, " address"}, base + exp_off, beat_q[1]);
            for (int i = 0; i < n; i++) begin
                check_qword({name, " payload"}, ram_word(exp_ptr + buf_addr_t'(i)),
                            beat_q[i + 2]);
            end
        end
        exp_ptr = exp_ptr + buf_addr_t'(n);
        exp_off = exp_off + host_addr_t'(8 * n);
        check_addr({name, " committed pointer"}, exp_ptr, rx_commited_rd_address);
        repeat (2) tick();
        check_bit({name, " single ack"}, 1'b1, ack_cnt == acks + 1);
    endtask

    task automatic change_page(string name);
        int waited;
        waited = 0;
        tick();
        rx_change_huge_page = 1'b1;
        do begin
            @(negedge trn_clk);
            waited++;
        end while (!rx_change_huge_page_ack && waited < WAIT_LIMIT);
        tick();
        rx_change_huge_page = 1'b0;
        if (waited >= WAIT_LIMIT) begin
            other_errs++;
            $display("%s: page change was not acknowledged in time", name);
        end
        exp_off = '0;                           // New page starts at offset 0
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_page_register();
        bar_write(REG_PAGE1_LO, PAGE1[31:0], 1'b1);
        check_bit("page_register status 1 after LO", 1'b0, rx_huge_page_status_1);
        bar_write(REG_PAGE1_HI, PAGE1[63:32], 1'b1);
        check_bit("page_register status 1", 1'b1, rx_huge_page_status_1);
        check_bit("page_register status 2", 1'b0, rx_huge_page_status_2);
        bar_write(REG_PAGE2_HI, 32'hDEAD_0000, 1'b0);   // Misses BAR0
        check_bit("page_register no hit", 1'b0, rx_huge_page_status_2);
    endtask

    task automatic test_single_tlp();
        start_trigger(5'd4);
        await_tlp("single_tlp", 5'd4, PAGE1);
        check_addr("single_tlp pointer", 10'd4, rx_commited_rd_address);
    endtask

    task automatic test_back_to_back_offsets();
        bp_en = 1'b1;
        start_trigger(5'd3);
        await_tlp("back_to_back 1", 5'd3, PAGE1);
        start_trigger(5'd16);
        await_tlp("back_to_back 2", 5'd16, PAGE1);
        start_trigger(5'd1);
        await_tlp("back_to_back 3", 5'd1, PAGE1);
        bp_en = 1'b0;
    endtask

    task automatic test_page_change_irq();
        int irqs;
        irqs      = irq_cnt;
        rdy_given = 1'b0;
        bar_write(REG_INT_EN, 32'h1, 1'b1);
        bar_write(REG_PAGE2_LO, PAGE2[31:0], 1'b1);
        bar_write(REG_PAGE2_HI, PAGE2[63:32], 1'b1);
        check_bit("page_change status 2", 1'b1, rx_huge_page_status_2);
        change_page("page_change");
        check_bit("page_change status 1", 1'b0, rx_huge_page_status_1);
        check_bit("page_change one interrupt", 1'b1, irq_cnt == irqs + 1);
        check_bit("page_change ready seen", 1'b1, rdy_given);
        check_bit("page_change released", 1'b1, cfg_interrupt_n);
        bp_en = 1'b1;
        start_trigger(5'd5);
        await_tlp("page_change tlp", 5'd5, PAGE2);
        bp_en = 1'b0;
    endtask

    task automatic test_irq_disabled_and_gating();
        int irqs;
        int acks;
        irqs = irq_cnt;
        bar_write(REG_INT_EN, 32'h0, 1'b1);
        change_page("irq_disabled");
        check_bit("irq_disabled no interrupt", 1'b1, irq_cnt == irqs);
        check_bit("irq_disabled status 2", 1'b0, rx_huge_page_status_2);
        acks = ack_cnt;
        start_trigger(5'd2);                    // Page 1 was freed earlier
        repeat (20) tick();
        check_bit("gating page not ready", 1'b1, ack_cnt == acks);
        cfg_command = 16'h0000;
        bar_write(REG_PAGE1_LO, PAGE3[31:0], 1'b1);
        bar_write(REG_PAGE1_HI, PAGE3[63:32], 1'b1);
        repeat (20) tick();
        check_bit("gating bus master off", 1'b1, ack_cnt == acks);
        cfg_command = 16'h0004;
        await_tlp("gating served", 5'd2, PAGE3);
    endtask

    initial begin : watchdog
        cycle = 0;
        while (cycle < RUN_LIMIT) begin
            @(posedge trn_clk);
            cycle++;
        end
        $display("Run stopped after %0d cycles with tests still running", cycle);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        seed                = 13;
        bp_en               = 1'b0;
        value_errs          = 0;
        other_errs          = 0;
        mon_pos             = 0;
        ack_cnt             = 0;
        irq_cnt             = 0;
        irq_low             = 0;
        rdy_given           = 1'b0;
        exp_ptr             = '0;
        exp_off             = '0;
        rst_n               = 1'b0;
        trn_rd              = '0;
        trn_rrem            = 8'h00;
        trn_rsof_n          = 1'b1;
        trn_reof_n          = 1'b1;
        trn_rsrc_rdy_n      = 1'b1;
        trn_rbar_hit_n      = 7'h7F;
        trn_tdst_rdy_n      = 1'b0;
        trn_tbuf_av         = 4'hF;
        cfg_command         = 16'h0004;         // Bus master enabled
        cfg_bus_number      = 8'h03;
        cfg_device_number   = 5'h01;
        cfg_function_number = 3'h2;
        cfg_interrupt_rdy_n = 1'b1;
        rx_trigger_tlp      = 1'b0;
        rx_qwords_to_send   = 5'd1;
        rx_change_huge_page = 1'b0;
        rx_rd_data          = '0;
        repeat (4) @(posedge trn_clk);
        #1 rst_n = 1'b1;
        test_page_register();
        test_single_tlp();
        test_back_to_back_offsets();
        test_page_change_irq();
        test_irq_disabled_and_gating();
        tick();
        $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== tlp_tx_builder.sv ====
`timescale 1ns/100ps
// Builds a 4DW memory-write TLP and streams its payload from the RX buffer RAM
// One-entry skid absorbs the RAM read latency under TX back-pressure
module tlp_tx_builder (
    input  logic                        trn_clk,
    input  logic                        rst_n,
    input  pcie_app_pkg::tlp_req_t      tlp_req,
    input  logic                        tlp_start,
    input  pcie_app_pkg::completer_id_t completer_id,
    input  pcie_app_pkg::qword_t        rd_data,
    input  logic                        trn_tdst_rdy_n,
    output pcie_app_pkg::buf_addr_t     rd_addr,
    output pcie_app_pkg::qword_t        trn_td,
    output logic                        trn_tsof_n,
    output logic                        trn_teof_n,
    output logic                        trn_tsrc_rdy_n,
    output logic                        tlp_done
);
    import pcie_app_pkg::*;

    tlp_req_t   req_q;
    logic       busy;
    logic [1:0] hdr_left;                       // Header beats not yet loaded
    qword_cnt_t rd_left;                        // RAM reads not yet issued
    qword_cnt_t data_left;                      // Payload beats not yet loaded
    logic       rd_pend;                        // rd_data valid this cycle
    logic       skid_vld;
    qword_t     skid_q;
    logic       out_vld;
    logic       out_sof;
    logic       out_eof;
    qword_t     out_q;
    logic       out_free;
    logic       pay_load;
    logic       skid_nxt;
    logic       skid_load;
    logic       issue;
    qword_t     hdr0;
    qword_t     hdr1;
    qword_t     pay_data;

    // Length in dwords with requester ID from config space and tag 0
    assign hdr0 = {TLP_MWR64, 14'd0, 4'd0, req_q.qwords, 1'b0,
                   completer_id, 8'h00, FULL_BE};
    assign hdr1 = {req_q.addr[63:2], 2'b00};

    assign out_free  = !out_vld || !trn_tdst_rdy_n;
    assign pay_load  = out_free && busy && (hdr_left == 2'd0) && (skid_vld || rd_pend);
    assign pay_data  = skid_vld ? skid_q : rd_data;   // Older qword goes first
    assign skid_nxt  = pay_load ? (skid_vld && rd_pend) : (skid_vld || rd_pend);
    assign skid_load = rd_pend && (skid_vld || !pay_load);
    // Reads start with header beat 1 and stop while the skid could overflow
    assign issue     = busy && (rd_left != '0) && !skid_nxt &&
                       ((hdr_left == 2'd0) || ((hdr_left == 2'd1) && out_free));
    assign tlp_done  = out_vld && out_eof && !trn_tdst_rdy_n;

    always_ff @(posedge trn_clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            hdr_left  <= 2'd0;
            rd_left   <= '0;
            data_left <= '0;
            rd_pend   <= 1'b0;
            skid_vld  <= 1'b0;
            out_vld   <= 1'b0;
            out_sof   <= 1'b0;
            out_eof   <= 1'b0;
            rd_addr   <= '0;
        end else begin
            rd_pend  <= issue;                  // RAM answers one cycle later
            skid_vld <= skid_nxt;
            if (issue) begin
                rd_addr <= rd_addr + 1'b1;
                rd_left <= rd_left - 1'b1;
            end
            if (tlp_start && !busy) begin
                busy      <= 1'b1;
                hdr_left  <= 2'd2;
                rd_left   <= tlp_req.qwords;
                data_left <= tlp_req.qwords;
                rd_addr   <= tlp_req.buf_start;
            end else if (tlp_done) begin
                busy <= 1'b0;
            end
            if (out_free) begin
                out_vld <= busy && ((hdr_left != 2'd0) || skid_vld || rd_pend);
                out_sof <= (hdr_left == 2'd2);
                out_eof <= (hdr_left == 2'd0) && (data_left == 5'd1);
                if (busy && (hdr_left != 2'd0)) begin
                    hdr_left <= hdr_left - 1'b1;
                end
                if (pay_load) begin
                    data_left <= data_left - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge trn_clk) begin
        if (tlp_start && !busy) begin
            req_q <= tlp_req;
        end
        if (out_free) begin
            out_q <= (hdr_left == 2'd2) ? hdr0 : (hdr_left == 2'd1) ? hdr1 : pay_data;
        end
        if (skid_load) begin
            skid_q <= rd_data;
        end
    end

    assign trn_td         = out_q;
    assign trn_tsrc_rdy_n = !out_vld;
    assign trn_tsof_n     = !(out_vld && out_sof);
    assign trn_teof_n     = !(out_vld && out_eof);

    // Every qword read from the RAM has gone out with the last beat
    a_drained: assert property (@(posedge trn_clk) disable iff (!rst_n)
        tlp_done |-> (rd_left == '0) && !skid_vld && !rd_pend);

endmodule
